/* Bender.yml */
package:
  name: soc_subsystem

sources:
  - logic/soc_pkg.sv
  - logic/bus_cut.sv
  - logic/addr_decoder.sv
  - logic/boot_rom.sv
  - logic/clint_regs.sv
  - logic/clint_timer.sv
  - logic/debug_req_gate.sv
  - logic/soc_subsystem.sv
  - target: test
    files:
      - bench/soc_subsystem_checker.sv
      - bench/tb_soc_subsystem.sv

/* bench/soc_subsystem_checker.sv */
`default_nettype none

module soc_subsystem_checker #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input wire logic              clk_i,
  input wire logic              ndmreset_n,
  input wire soc_pkg::bus_rsp_t rsp_i,
  input wire logic              rsp_valid_i,
  input wire logic              rsp_ready_i,
  input wire soc_pkg::bus_req_t cut_req_i,
  input wire logic              cut_req_valid_i,
  input wire logic              cut_req_ready_i,
  input wire soc_pkg::bus_req_t mem_req_i,
  input wire logic              mem_req_valid_i,
  input wire logic              reg_req_i,
  input wire soc_pkg::bus_req_t reg_req_payload_i,
  input wire soc_pkg::data_t    mtime_i,
  input wire soc_pkg::data_t    mtimecmp_i,
  input wire logic              timer_irq_i,
  input wire logic              ipi_i,
  input wire logic              debug_req_in_i,
  input wire logic              debug_req_out_i
);

  int unsigned fail_count = 0;
  int unsigned cycles_q;
  logic        to_l2;

  assign to_l2 = (cut_req_i.addr >= soc_pkg::L2Base) &&
                 (cut_req_i.addr < soc_pkg::L2Base + soc_pkg::L2Length);

  // Edges since reset release, saturating just past the debug window
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles_q <= 0;
    end else if (cycles_q <= DebugDelayCycles) begin
      cycles_q <= cycles_q + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Bus behavior
  // --------------------------------------------------------------------------
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      $error("response changed or dropped while stalled");
      fail_count++;
    end

  a_err_no_mem: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    cut_req_valid_i && cut_req_ready_i && !to_l2 |=> !mem_req_valid_i)
    else begin
      $error("L2 request for an address outside the L2 range");
      fail_count++;
    end

  // Base already removed on the external port
  a_mem_offset: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    mem_req_valid_i |-> mem_req_i.addr < soc_pkg::L2Length)
    else begin
      $error("L2 request address still carries the base");
      fail_count++;
    end

  // --------------------------------------------------------------------------
  // CLINT and debug gate
  // --------------------------------------------------------------------------
  a_timer_irq: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    1'b1 |=> timer_irq_i == $past(mtime_i >= mtimecmp_i))
    else begin
      $error("timer interrupt does not follow the mtime compare");
      fail_count++;
    end

  a_msip_write: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    reg_req_i && reg_req_payload_i.we &&
    reg_req_payload_i.addr == soc_pkg::ClintMsipOffset
    |=> ipi_i == $past(reg_req_payload_i.wdata[0]))
    else begin
      $error("software interrupt does not follow the msip write");
      fail_count++;
    end

  a_debug_masked: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    cycles_q <= DebugDelayCycles |-> !debug_req_out_i)
    else begin
      $error("debug request passed inside the mask window");
      fail_count++;
    end

  a_debug_follow: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    cycles_q > DebugDelayCycles |-> debug_req_out_i == $past(debug_req_in_i))
    else begin
      $error("debug request not forwarded after the mask window");
      fail_count++;
    end

endmodule

bind soc_subsystem soc_subsystem_checker #(
  .DebugDelayCycles(DebugDelayCycles)
) i_checker (
  .clk_i, .ndmreset_n,
  .rsp_i(rsp_o), .rsp_valid_i(rsp_valid_o), .rsp_ready_i,
  .cut_req_i(cut_req), .cut_req_valid_i(cut_req_valid), .cut_req_ready_i(cut_req_ready),
  .mem_req_i(mem_req_o), .mem_req_valid_i(mem_req_valid_o),
  .reg_req_i(reg_req), .reg_req_payload_i(reg_req_payload),
  .mtime_i(mtime), .mtimecmp_i(mtimecmp), .timer_irq_i(timer_irq_o), .ipi_i(ipi_o),
  .debug_req_in_i(debug_req_i), .debug_req_out_i(debug_req_o)
);

`default_nettype wire

/* bench/tb_soc_subsystem.sv */
`default_nettype none

module tb_soc_subsystem;

  localparam int unsigned Skew      = 5;
  localparam int unsigned WaitLimit = 200;

  typedef struct packed {
    soc_pkg::data_t rdata;
    logic           err;
    logic           check_data;
  } expect_t;

  logic              clk_i;
  logic              ndmreset_n;
  soc_pkg::bus_req_t req_i;
  logic              req_valid_i;
  logic              req_ready_o;
  soc_pkg::bus_rsp_t rsp_o;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  soc_pkg::bus_req_t mem_req_o;
  logic              mem_req_valid_o;
  logic              mem_req_ready_i;
  soc_pkg::bus_rsp_t mem_rsp_i;
  logic              mem_rsp_valid_i;
  logic              mem_rsp_ready_o;
  logic              tick_i;
  logic              timer_irq_o;
  logic              ipi_o;
  logic              debug_req_i;
  logic              debug_req_o;

  logic [31:0]       rng_state = 32'd85;
  expect_t           exp_q[$];
  soc_pkg::addr_t    mem_addr_q[$];
  soc_pkg::data_t    l2_mem[256];
  soc_pkg::data_t    l2_shadow[256];

  soc_subsystem #(.DebugDelayCycles(24)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Power-up contents of L2, a hash of the full bus address
  function automatic soc_pkg::data_t fill_word(input int unsigned idx);
    return ((soc_pkg::L2Base + (idx << 2)) * 32'h9E37_79B1) ^ 32'hA5A5_5A5A;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    stop_with_failure($sformatf("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic send(input soc_pkg::addr_t addr, input logic we, input soc_pkg::data_t wdata,
                      input soc_pkg::data_t exp_rdata, input logic exp_err);
    int unsigned n;
    exp_q.push_back('{rdata: exp_rdata, err: exp_err, check_data: ~we | exp_err});
    if (!exp_err && addr >= soc_pkg::L2Base) begin
      mem_addr_q.push_back(addr - soc_pkg::L2Base);
    end
    req_i       = '{addr: addr, we: we, wdata: wdata};
    req_valid_i = 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) begin
        stop_with_failure("Request was not accepted before the timeout");
      end
    end while (!req_ready_o);
    #Skew;
    req_valid_i = 1'b0;
  endtask

  task automatic l2_access(input logic [3:0] word, input logic we, input soc_pkg::data_t wdata);
    soc_pkg::addr_t off;
    off = soc_pkg::addr_t'(word) << 2;
    if (we) begin
      l2_shadow[word] = wdata;
      send(soc_pkg::L2Base + off, 1'b1, wdata, '0, 1'b0);
    end else begin
      send(soc_pkg::L2Base + off, 1'b0, '0, l2_shadow[word], 1'b0);
    end
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #Skew;
      n++;
      if (n > WaitLimit) begin
        stop_with_failure("Responses did not all return before the timeout");
      end
    end
  endtask

  task automatic wait_timer_irq(input logic level);
    int unsigned n;
    n = 0;
    while (timer_irq_o != level) begin
      @(posedge clk_i);
      #Skew;
      n++;
      if (n > WaitLimit) begin
        stop_with_failure("Timer interrupt did not reach the expected level in time");
      end
    end
  endtask

  task automatic pulse_tick(input int unsigned count);
    repeat (count) begin
      tick_i = 1'b1;
      @(posedge clk_i);
      #Skew;
      tick_i = 1'b0;
      @(posedge clk_i);
      #Skew;
    end
  endtask

  // --------------------------------------------------------------------------
  // Response scoreboard and L2 model
  // --------------------------------------------------------------------------
  initial begin : response_monitor
    expect_t e;
    forever begin
      @(posedge clk_i);
      if (ndmreset_n && rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("Response arrived with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          assert (rsp_o.err == e.err) else value_error("rsp_o.err", rsp_o.err, e.err);
          assert (!e.check_data || rsp_o.rdata == e.rdata)
            else value_error("rsp_o.rdata", rsp_o.rdata, e.rdata);
        end
      end
    end
  end

  // Random ready and latency on the L2 side, random stall on the response side
  initial begin : l2_model
    soc_pkg::bus_req_t mreq;
    soc_pkg::data_t    rsp_data;
    soc_pkg::addr_t    exp_addr;
    logic [31:0]       r;
    int unsigned       delay;
    logic              busy;
    logic              rsp_taken;
    busy     = 1'b0;
    delay    = 0;
    rsp_data = '0;
    forever begin
      @(posedge clk_i);
      rsp_taken = mem_rsp_valid_i & mem_rsp_ready_o;
      if (ndmreset_n && mem_req_valid_o && mem_req_ready_i) begin
        mreq = mem_req_o;
        if (mem_addr_q.size() == 0) begin
          stop_with_failure("L2 request appeared with no bus request behind it");
        end else begin
          exp_addr = mem_addr_q.pop_front();
          assert (mreq.addr == exp_addr) else value_error("mem_req_o.addr", mreq.addr, exp_addr);
        end
        if (mreq.we) begin
          l2_mem[mreq.addr[9:2]] = mreq.wdata;
        end
        rsp_data = mreq.we ? '0 : l2_mem[mreq.addr[9:2]];
        r        = next_rand();
        delay    = r[1:0];
        busy     = 1'b1;
      end
      // Drawn at the edge, the main stimulus draws after the skew
      r = next_rand();
      #Skew;
      mem_req_ready_i = r[0];
      rsp_ready_i     = r[1] | r[2];
      if (rsp_taken) begin
        mem_rsp_valid_i = 1'b0;
      end
      if (busy && delay == 0) begin
        mem_rsp_i       = '{rdata: rsp_data, err: 1'b0};
        mem_rsp_valid_i = 1'b1;
        busy            = 1'b0;
      end else if (busy) begin
        delay--;
      end
    end
  end

  initial begin : checker_watch
    forever begin
      @(negedge clk_i);
      if (i_dut.i_checker.fail_count != 0) begin
        stop_with_failure("A concurrent assertion in the checker failed");
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : main
    int unsigned k;
    int unsigned tick_edges;
    logic [31:0] r;
    ndmreset_n      = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    rsp_ready_i     = 1'b1;
    mem_req_ready_i = 1'b1;
    mem_rsp_i       = '0;
    mem_rsp_valid_i = 1'b0;
    tick_i          = 1'b0;
    // Held high from reset on
    debug_req_i     = 1'b1;
    for (k = 0; k < 256; k++) begin
      l2_mem[k]    = fill_word(k);
      l2_shadow[k] = fill_word(k);
    end
    repeat (8) @(posedge clk_i);
    #Skew;
    ndmreset_n = 1'b1;
    assert (req_ready_o) else value_error("req_ready_o", req_ready_o, 1);
    assert (!rsp_valid_o) else value_error("rsp_valid_o", rsp_valid_o, 0);
    assert (!mem_req_valid_o) else value_error("mem_req_valid_o", mem_req_valid_o, 0);
    assert (!timer_irq_o) else value_error("timer_irq_o", timer_irq_o, 0);
    assert (!ipi_o) else value_error("ipi_o", ipi_o, 0);

    // Boot ROM reads past the image end, then a rejected write
    for (k = 0; k < 20; k++) begin
      send(soc_pkg::RomBase + 4 * k, 1'b0, '0, soc_pkg::rom_word(k % soc_pkg::RomWords), 1'b0);
    end
    send(soc_pkg::RomBase + 8, 1'b1, 32'hDEAD_BEEF, '0, 1'b1);
    drain();

    // Holes in the map
    send(32'h0000_0000, 1'b0, '0, '0, 1'b1);
    send(32'h3000_0000, 1'b1, 32'h1234_5678, '0, 1'b1);
    send(soc_pkg::ClintBase + soc_pkg::ClintLength, 1'b0, '0, '0, 1'b1);
    send(soc_pkg::L2Base + soc_pkg::L2Length, 1'b1, 32'h0BAD_F00D, '0, 1'b1);
    drain();

    // L2 traffic over a few words so reads see earlier writes
    for (k = 0; k < 48; k++) begin
      r = next_rand();
      l2_access(r[5:2], r[6], next_rand());
    end
    drain();

    // Software interrupt
    send(soc_pkg::ClintBase + soc_pkg::ClintMsipOffset, 1'b1, 32'd1, '0, 1'b0);
    send(soc_pkg::ClintBase + soc_pkg::ClintMsipOffset, 1'b0, '0, 32'd1, 1'b0);
    drain();
    assert (ipi_o) else value_error("ipi_o", ipi_o, 1);
    send(soc_pkg::ClintBase + soc_pkg::ClintMsipOffset, 1'b1, 32'd0, '0, 1'b0);
    drain();
    assert (!ipi_o) else value_error("ipi_o", ipi_o, 0);

    // Machine timer against a small compare value
    send(soc_pkg::ClintBase + soc_pkg::ClintMtimecmpOffset, 1'b1, 32'd3, '0, 1'b0);
    send(soc_pkg::ClintBase + soc_pkg::ClintMtimecmpOffset, 1'b0, '0, 32'd3, 1'b0);
    drain();
    assert (!timer_irq_o) else value_error("timer_irq_o", timer_irq_o, 0);
    tick_edges = 7;
    pulse_tick(tick_edges);
    send(soc_pkg::ClintBase + soc_pkg::ClintMtimeOffset, 1'b0, '0, tick_edges / 2, 1'b0);
    drain();
    wait_timer_irq(1'b1);
    send(soc_pkg::ClintBase + soc_pkg::ClintMtimecmpOffset, 1'b1, '1, '0, 1'b0);
    drain();
    wait_timer_irq(1'b0);

    repeat (4) @(posedge clk_i);
    if (i_dut.i_checker.fail_count != 0) begin
      stop_with_failure("A concurrent assertion in the checker failed");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* logic/addr_decoder.sv */
`default_nettype none

module addr_decoder (
  input  wire logic              clk_i,
  input  wire logic              ndmreset_n,
  // Upstream request and response
  input  wire soc_pkg::bus_req_t req_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  output soc_pkg::bus_rsp_t      rsp_o,
  output logic                   rsp_valid_o,
  input  wire logic              rsp_ready_i,
  // Boot ROM
  output logic                   rom_req_o,
  output soc_pkg::addr_t         rom_addr_o,
  input  wire soc_pkg::data_t    rom_rdata_i,
  // CLINT registers
  output logic                   reg_req_o,
  output soc_pkg::bus_req_t      reg_req_payload_o,
  input  wire soc_pkg::data_t    reg_rdata_i,
  // External L2 port
  output soc_pkg::bus_req_t      mem_req_o,
  output logic                   mem_req_valid_o,
  input  wire logic              mem_req_ready_i,
  input  wire soc_pkg::bus_rsp_t mem_rsp_i,
  input  wire logic              mem_rsp_valid_i,
  output logic                   mem_rsp_ready_o
);

  typedef enum logic [2:0] {
    StIdle,
    StRom,
    StReg,
    StErr,
    StMemReq,
    StMemRsp
  } state_e;

  state_e            state_d, state_q;
  soc_pkg::target_e  tgt;
  soc_pkg::addr_t    base;
  soc_pkg::bus_req_t req_off;
  soc_pkg::bus_req_t mem_q;
  logic              accept;

  // --------------------------------------------------------------------------
  // Address match
  // --------------------------------------------------------------------------
  always_comb begin
    tgt  = soc_pkg::TgtNone;
    base = '0;
    for (int unsigned i = 0; i < $size(soc_pkg::AddrMap); i++) begin
      if (req_i.addr >= soc_pkg::AddrMap[i].start_addr &&
          req_i.addr <  soc_pkg::AddrMap[i].end_addr) begin
        tgt  = soc_pkg::AddrMap[i].idx;
        base = soc_pkg::AddrMap[i].start_addr;
      end
    end
  end

  // Target-relative request
  assign req_off = '{addr: req_i.addr - base, we: req_i.we, wdata: req_i.wdata};

  // One transaction at a time, and only with room for its reply
  assign req_ready_o = (state_q == StIdle) & rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign rom_req_o         = accept & (tgt == soc_pkg::TgtRom) & ~req_i.we;
  assign rom_addr_o        = req_off.addr;
  assign reg_req_o         = accept & (tgt == soc_pkg::TgtClint);
  assign reg_req_payload_o = req_off;

  assign mem_req_o       = mem_q;
  assign mem_req_valid_o = (state_q == StMemReq);
  assign mem_rsp_ready_o = (state_q == StMemRsp) & rsp_ready_i;

  // --------------------------------------------------------------------------
  // Response mux
  // --------------------------------------------------------------------------
  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_o       = '{rdata: '0, err: 1'b1};
    unique case (state_q)
      StRom: begin
        rsp_valid_o = 1'b1;
        rsp_o       = '{rdata: rom_rdata_i, err: 1'b0};
      end
      StReg: begin
        rsp_valid_o = 1'b1;
        rsp_o       = '{rdata: reg_rdata_i, err: 1'b0};
      end
      StErr: rsp_valid_o = 1'b1;
      StMemRsp: begin
        rsp_valid_o = mem_rsp_valid_i;
        rsp_o       = mem_rsp_i;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (accept) begin
          unique case (tgt)
            soc_pkg::TgtRom:   state_d = req_i.we ? StErr : StRom;
            soc_pkg::TgtClint: state_d = StReg;
            soc_pkg::TgtL2:    state_d = StMemReq;
            default:           state_d = StErr;
          endcase
        end
      end
      StRom, StReg, StErr: begin
        if (rsp_ready_i) begin
          state_d = StIdle;
        end
      end
      StMemReq: begin
        if (mem_req_ready_i) begin
          state_d = StMemRsp;
        end
      end
      StMemRsp: begin
        if (mem_rsp_valid_i && rsp_ready_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // L2 request held until the memory takes it
  always_ff @(posedge clk_i) begin
    if (accept && tgt == soc_pkg::TgtL2) begin
      mem_q <= req_off;
    end
  end

endmodule

`default_nettype wire

/* logic/boot_rom.sv */
`default_nettype none

module boot_rom (
  input  wire logic           clk_i,
  input  wire logic           ndmreset_n,
  input  wire logic           req_i,
  input  wire soc_pkg::addr_t addr_i,
  output soc_pkg::data_t      rdata_o
);

  int unsigned word_idx;

  // Word index, wrapping over the image
  assign word_idx = int'(addr_i[5:2]) % soc_pkg::RomWords;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= soc_pkg::rom_word(word_idx);
    end
  end

endmodule

`default_nettype wire

/* logic/bus_cut.sv */
`default_nettype none

// One-entry register slice on a valid/ready channel
module bus_cut #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     ndmreset_n,
  input  wire payload_t in_i,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  output payload_t      out_o,
  output logic          out_valid_o,
  input  wire logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Space when empty, or when the held item leaves this cycle
  assign in_ready_o  = ~valid_q | out_ready_i;
  assign out_valid_o = valid_q;
  assign out_o       = data_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

endmodule

`default_nettype wire

/* logic/clint_regs.sv */
`default_nettype none

module clint_regs (
  input  wire logic              clk_i,
  input  wire logic              ndmreset_n,
  input  wire logic              req_i,
  input  wire soc_pkg::bus_req_t req_payload_i,
  output soc_pkg::data_t         rdata_o,
  input  wire soc_pkg::data_t    mtime_i,
  output soc_pkg::data_t         mtimecmp_o,
  output logic                   ipi_o
);

  soc_pkg::data_t mtimecmp_q;
  soc_pkg::data_t rdata_d;
  logic           msip_q;
  logic           wr;

  assign wr         = req_i & req_payload_i.we;
  assign mtimecmp_o = mtimecmp_q;
  assign ipi_o      = msip_q;

  // Read mux, unknown offsets give zero
  always_comb begin
    unique case (req_payload_i.addr)
      soc_pkg::ClintMtimecmpOffset: rdata_d = mtimecmp_q;
      soc_pkg::ClintMtimeOffset:    rdata_d = mtime_i;
      soc_pkg::ClintMsipOffset:     rdata_d = soc_pkg::data_t'(msip_q);
      default:                      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      // Compare starts at the maximum so no timer interrupt out of reset
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rdata_o    <= '0;
    end else begin
      if (wr && req_payload_i.addr == soc_pkg::ClintMtimecmpOffset) begin
        mtimecmp_q <= req_payload_i.wdata;
      end
      if (wr && req_payload_i.addr == soc_pkg::ClintMsipOffset) begin
        msip_q <= req_payload_i.wdata[0];
      end
      if (req_i) begin
        rdata_o <= rdata_d;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/clint_timer.sv */
`default_nettype none

module clint_timer (
  input  wire logic           clk_i,
  input  wire logic           ndmreset_n,
  input  wire logic           tick_i,
  input  wire soc_pkg::data_t mtimecmp_i,
  output soc_pkg::data_t      mtime_o,
  output logic                timer_irq_o
);

  logic           tick_q;
  logic           half_q;
  logic           tick_rise;
  soc_pkg::data_t mtime_q;

  // tick_i is already synchronous to clk_i
  assign tick_rise = tick_i & ~tick_q;
  assign mtime_o   = mtime_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      tick_q      <= 1'b0;
      half_q      <= 1'b0;
      mtime_q     <= '0;
      timer_irq_o <= 1'b0;
    end else begin
      tick_q <= tick_i;
      // Divide by two: count on every second rising tick
      if (tick_rise) begin
        half_q <= ~half_q;
        if (half_q) begin
          mtime_q <= mtime_q + 1'b1;
        end
      end
      timer_irq_o <= (mtime_q >= mtimecmp_i);
    end
  end

endmodule

`default_nettype wire

/* logic/debug_req_gate.sv */
`default_nettype none

// Holds off debug requests while the hart runs its boot code after reset
module debug_req_gate #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input  wire logic clk_i,
  input  wire logic ndmreset_n,
  input  wire logic debug_req_i,
  output logic      debug_req_o
);

  localparam int unsigned CntWidth = $clog2(DebugDelayCycles + 2);

  logic [CntWidth-1:0] cnt_q;
  logic                window;

  assign window = (cnt_q != '0);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q       <= CntWidth'(DebugDelayCycles);
      debug_req_o <= 1'b0;
    end else begin
      if (window) begin
        cnt_q <= cnt_q - 1'b1;
      end
      debug_req_o <= debug_req_i & ~window;
    end
  end

endmodule

`default_nettype wire

/* logic/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths and payloads
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0001_0000;
  localparam addr_t L2Base      = 32'h1C00_0000;
  localparam addr_t L2Length    = 32'h0010_0000;

  typedef enum logic [1:0] {
    TgtRom,
    TgtClint,
    TgtL2,
    TgtNone
  } target_e;

  // Start is inclusive, end is exclusive
  typedef struct packed {
    target_e idx;
    addr_t   start_addr;
    addr_t   end_addr;
  } addr_rule_t;

  localparam addr_rule_t AddrMap [3] = '{
    '{idx: TgtRom,   start_addr: RomBase,   end_addr: RomBase + RomLength},
    '{idx: TgtClint, start_addr: ClintBase, end_addr: ClintBase + ClintLength},
    '{idx: TgtL2,    start_addr: L2Base,    end_addr: L2Base + L2Length}
  };

  // CLINT register offsets
  localparam addr_t ClintMtimecmpOffset = 32'h0000_0000;
  localparam addr_t ClintMtimeOffset    = 32'h0000_0008;
  localparam addr_t ClintMsipOffset     = 32'h0000_0010;

  // Boot image
  localparam int unsigned RomWords = 16;

  function automatic data_t rom_word(input int unsigned idx);
    return data_t'(32'hB007_0000 + idx * 32'h0000_0101);
  endfunction

endpackage

`default_nettype wire

/* logic/soc_subsystem.sv */
`default_nettype none

module soc_subsystem #(
  parameter int unsigned DebugDelayCycles = 500
) (
  input  wire logic              clk_i,
  input  wire logic              ndmreset_n,
  // Requester port
  input  wire soc_pkg::bus_req_t req_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  output soc_pkg::bus_rsp_t      rsp_o,
  output logic                   rsp_valid_o,
  input  wire logic              rsp_ready_i,
  // External L2 memory
  output soc_pkg::bus_req_t      mem_req_o,
  output logic                   mem_req_valid_o,
  input  wire logic              mem_req_ready_i,
  input  wire soc_pkg::bus_rsp_t mem_rsp_i,
  input  wire logic              mem_rsp_valid_i,
  output logic                   mem_rsp_ready_o,
  // Timer, interrupts and debug
  input  wire logic              tick_i,
  output logic                   timer_irq_o,
  output logic                   ipi_o,
  input  wire logic              debug_req_i,
  output logic                   debug_req_o
);

  soc_pkg::bus_req_t cut_req;
  logic              cut_req_valid;
  logic              cut_req_ready;
  soc_pkg::bus_rsp_t dec_rsp;
  logic              dec_rsp_valid;
  logic              dec_rsp_ready;

  logic              rom_req;
  soc_pkg::addr_t    rom_addr;
  soc_pkg::data_t    rom_rdata;
  logic              reg_req;
  soc_pkg::bus_req_t reg_req_payload;
  soc_pkg::data_t    reg_rdata;
  soc_pkg::data_t    mtime;
  soc_pkg::data_t    mtimecmp;

  // --------------------------------------------------------------------------
  // Bus path
  // --------------------------------------------------------------------------
  bus_cut #(.payload_t(soc_pkg::bus_req_t)) i_req_cut (
    .clk_i, .ndmreset_n,
    .in_i(req_i), .in_valid_i(req_valid_i), .in_ready_o(req_ready_o),
    .out_o(cut_req), .out_valid_o(cut_req_valid), .out_ready_i(cut_req_ready)
  );

  addr_decoder i_decoder (
    .clk_i, .ndmreset_n,
    .req_i(cut_req), .req_valid_i(cut_req_valid), .req_ready_o(cut_req_ready),
    .rsp_o(dec_rsp), .rsp_valid_o(dec_rsp_valid), .rsp_ready_i(dec_rsp_ready),
    .rom_req_o(rom_req), .rom_addr_o(rom_addr), .rom_rdata_i(rom_rdata),
    .reg_req_o(reg_req), .reg_req_payload_o(reg_req_payload), .reg_rdata_i(reg_rdata),
    .mem_req_o, .mem_req_valid_o, .mem_req_ready_i,
    .mem_rsp_i, .mem_rsp_valid_i, .mem_rsp_ready_o
  );

  bus_cut #(.payload_t(soc_pkg::bus_rsp_t)) i_rsp_cut (
    .clk_i, .ndmreset_n,
    .in_i(dec_rsp), .in_valid_i(dec_rsp_valid), .in_ready_o(dec_rsp_ready),
    .out_o(rsp_o), .out_valid_o(rsp_valid_o), .out_ready_i(rsp_ready_i)
  );

  // --------------------------------------------------------------------------
  // Targets
  // --------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i, .ndmreset_n,
    .req_i(rom_req), .addr_i(rom_addr), .rdata_o(rom_rdata)
  );

  clint_regs i_clint_regs (
    .clk_i, .ndmreset_n,
    .req_i(reg_req), .req_payload_i(reg_req_payload), .rdata_o(reg_rdata),
    .mtime_i(mtime), .mtimecmp_o(mtimecmp), .ipi_o
  );

  clint_timer i_clint_timer (
    .clk_i, .ndmreset_n,
    .tick_i, .mtimecmp_i(mtimecmp), .mtime_o(mtime), .timer_irq_o
  );

  debug_req_gate #(.DebugDelayCycles(DebugDelayCycles)) i_debug_gate (
    .clk_i, .ndmreset_n,
    .debug_req_i, .debug_req_o
  );

endmodule

`default_nettype wire

/* verilog.f */
logic/soc_pkg.sv
logic/bus_cut.sv
logic/addr_decoder.sv
logic/boot_rom.sv
logic/clint_regs.sv
logic/clint_timer.sv
logic/debug_req_gate.sv
logic/soc_subsystem.sv
bench/soc_subsystem_checker.sv
bench/tb_soc_subsystem.sv
